// ==== logic/bus_pkg.sv ====
package bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [63:0] axi_data_t;
  typedef logic [7:0]  strb_t;      // only [3:0] meaningful from the lsu
  typedef logic [2:0]  axi_size_t;
  typedef logic [7:0]  axi_len_t;
  typedef logic [1:0]  axi_burst_t;
  typedef logic [3:0]  axi_id_t;
  typedef logic [1:0]  axi_resp_t;

  typedef enum logic [2:0] {
    st_idle,
    st_ifu,
    st_lsu_rd,
    st_lsu_wr,
    st_timer
  } arb_state_e;

  // real-time clock, low and high word
  localparam addr_t rtc_addr_lo = 32'h0200_0000;
  localparam addr_t rtc_addr_hi = 32'h0200_0004;

  localparam axi_size_t size_byte = 3'd0;
  localparam axi_size_t size_half = 3'd1;
  localparam axi_size_t size_word = 3'd2;

  localparam axi_len_t   axi_len_single = 8'd0;
  localparam axi_burst_t axi_burst_incr = 2'b01;
  localparam axi_id_t    axi_id_zero    = 4'd0;

  localparam strb_t strb_word = 8'h0f;  // fetches are always full words

endpackage

// ==== logic/bus_req_if.sv ====
`timescale 1ns/1ns

// one granted request between the arbiter and a target
interface bus_req_if import bus_pkg::*; ();

  logic  req;     // one-cycle start strobe
  logic  write;
  addr_t addr;
  word_t wdata;
  strb_t strb;
  word_t rdata;   // valid with done
  logic  done;    // one-cycle end strobe

  modport master (
    output req, write, addr, wdata, strb,
    input  rdata, done
  );

  modport target (
    input  req, write, addr, wdata, strb,
    output rdata, done
  );

endinterface

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/1ns

module bus_arbiter import bus_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  input  logic      ifu_arvalid_i,
  input  addr_t     ifu_araddr_i,
  output word_t     ifu_rdata_o,
  output logic      ifu_rvalid_o,

  input  logic      lsu_arvalid_i,
  input  addr_t     lsu_araddr_i,
  input  strb_t     lsu_rstrb_i,
  output word_t     lsu_rdata_o,
  output logic      lsu_rdone_o,

  input  logic      lsu_awvalid_i,
  input  addr_t     lsu_awaddr_i,
  input  word_t     lsu_wdata_i,
  input  strb_t     lsu_wstrb_i,
  output logic      lsu_wdone_o,

  bus_req_if.master axi_req,
  bus_req_if.master tmr_req
);

  arb_state_e state_q;
  logic       last_lsu_q;   // set when the lsu was granted last
  logic       req_q;

  logic  write_q;
  addr_t addr_q;
  word_t wdata_q;
  strb_t strb_q;

  logic lsu_pend;
  logic pick_ifu;
  logic lsu_is_rtc;

  assign lsu_pend   = lsu_arvalid_i | lsu_awvalid_i;
  assign pick_ifu   = ifu_arvalid_i & (~lsu_pend | last_lsu_q);  // round robin on contention
  assign lsu_is_rtc = (lsu_araddr_i == rtc_addr_lo) | (lsu_araddr_i == rtc_addr_hi);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= st_idle;
      last_lsu_q <= 1'b1;
      req_q      <= 1'b0;
    end else begin
      req_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (pick_ifu) begin
            state_q    <= st_ifu;
            last_lsu_q <= 1'b0;
            req_q      <= 1'b1;
          end else if (lsu_arvalid_i) begin
            state_q    <= lsu_is_rtc ? st_timer : st_lsu_rd;
            last_lsu_q <= 1'b1;
            req_q      <= 1'b1;
          end else if (lsu_awvalid_i) begin
            state_q    <= st_lsu_wr;
            last_lsu_q <= 1'b1;
            req_q      <= 1'b1;
          end
        end
        st_ifu, st_lsu_rd, st_lsu_wr: begin
          if (axi_req.done) state_q <= st_idle;
        end
        st_timer: begin
          if (tmr_req.done) state_q <= st_idle;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // request fields, held until done
  always_ff @(posedge clk) begin
    if (state_q == st_idle) begin
      if (pick_ifu) begin
        write_q <= 1'b0;
        addr_q  <= ifu_araddr_i;
        wdata_q <= '0;
        strb_q  <= strb_word;
      end else if (lsu_arvalid_i) begin
        write_q <= 1'b0;
        addr_q  <= lsu_araddr_i;
        wdata_q <= '0;
        strb_q  <= lsu_rstrb_i;
      end else begin
        write_q <= 1'b1;
        addr_q  <= lsu_awaddr_i;
        wdata_q <= lsu_wdata_i;
        strb_q  <= lsu_wstrb_i;
      end
    end
  end

  assign axi_req.req   = req_q & (state_q != st_timer);
  assign axi_req.write = write_q;
  assign axi_req.addr  = addr_q;
  assign axi_req.wdata = wdata_q;
  assign axi_req.strb  = strb_q;

  assign tmr_req.req   = req_q & (state_q == st_timer);
  assign tmr_req.write = write_q;
  assign tmr_req.addr  = addr_q;
  assign tmr_req.wdata = wdata_q;
  assign tmr_req.strb  = strb_q;

  // responses back to whoever holds the grant
  assign ifu_rvalid_o = (state_q == st_ifu) & axi_req.done;
  assign ifu_rdata_o  = axi_req.rdata;

  assign lsu_rdone_o = ((state_q == st_lsu_rd) & axi_req.done) |
                       ((state_q == st_timer) & tmr_req.done);
  assign lsu_rdata_o = (state_q == st_timer) ? tmr_req.rdata : axi_req.rdata;

  assign lsu_wdone_o = (state_q == st_lsu_wr) & axi_req.done;

endmodule

// ==== logic/axi_master_bridge.sv ====
`timescale 1ns/1ns

module axi_master_bridge import bus_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  bus_req_if.target  req,

  output addr_t      m_araddr_o,
  output axi_size_t  m_arsize_o,
  output axi_len_t   m_arlen_o,
  output axi_burst_t m_arburst_o,
  output axi_id_t    m_arid_o,
  output logic       m_arvalid_o,
  input  logic       m_arready_i,

  input  axi_data_t  m_rdata_i,
  input  logic       m_rvalid_i,
  input  logic       m_rlast_i,
  input  axi_resp_t  m_rresp_i,
  output logic       m_rready_o,

  output addr_t      m_awaddr_o,
  output axi_size_t  m_awsize_o,
  output axi_len_t   m_awlen_o,
  output axi_burst_t m_awburst_o,
  output axi_id_t    m_awid_o,
  output logic       m_awvalid_o,
  input  logic       m_awready_i,

  output axi_data_t  m_wdata_o,
  output strb_t      m_wstrb_o,
  output logic       m_wlast_o,
  output logic       m_wvalid_o,
  input  logic       m_wready_i,

  input  logic       m_bvalid_i,
  input  axi_resp_t  m_bresp_i,
  output logic       m_bready_o
);

  logic rd_pend_q;
  logic ar_done_q;
  logic wr_pend_q;
  logic aw_done_q;  // aw and w may finish in either order
  logic w_done_q;

  logic       rd_done;
  logic       wr_done;
  axi_size_t  req_size;
  logic [1:0] lane_off;
  word_t      wdata_sh;
  logic [3:0] strb_sh;

  function automatic axi_size_t size_of(strb_t s);
    axi_size_t sz;
    case (s)
      8'h01:   sz = size_byte;
      8'h03:   sz = size_half;
      default: sz = size_word;
    endcase
    return sz;
  endfunction

  assign rd_done = rd_pend_q & ar_done_q & m_rvalid_i & m_rlast_i;
  assign wr_done = wr_pend_q & aw_done_q & w_done_q & m_bvalid_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pend_q <= 1'b0;
      ar_done_q <= 1'b0;
      wr_pend_q <= 1'b0;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else if (req.req) begin
      rd_pend_q <= ~req.write;
      wr_pend_q <= req.write;
      ar_done_q <= 1'b0;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      if (m_arvalid_o & m_arready_i) ar_done_q <= 1'b1;
      if (m_awvalid_o & m_awready_i) aw_done_q <= 1'b1;
      if (m_wvalid_o & m_wready_i) w_done_q <= 1'b1;
      if (rd_done) rd_pend_q <= 1'b0;
      if (wr_done) wr_pend_q <= 1'b0;
    end
  end

  assign req_size = size_of(req.strb);
  assign lane_off = req.addr[1:0];

  // read address
  assign m_araddr_o  = req.addr;
  assign m_arsize_o  = req_size;
  assign m_arlen_o   = axi_len_single;
  assign m_arburst_o = axi_burst_incr;
  assign m_arid_o    = axi_id_zero;
  assign m_arvalid_o = rd_pend_q & ~ar_done_q;

  assign m_rready_o = 1'b1;

  // write address
  assign m_awaddr_o  = req.addr;
  assign m_awsize_o  = req_size;
  assign m_awlen_o   = axi_len_single;
  assign m_awburst_o = axi_burst_incr;
  assign m_awid_o    = axi_id_zero;
  assign m_awvalid_o = wr_pend_q & ~aw_done_q;

  // store lane alignment
  assign wdata_sh = req.wdata << {lane_off, 3'b000};
  assign strb_sh  = req.strb[3:0] << lane_off;

  assign m_wdata_o  = {wdata_sh, wdata_sh};  // same word on both halves
  assign m_wstrb_o  = req.addr[2] ? {strb_sh, 4'h0} : {4'h0, strb_sh};
  assign m_wlast_o  = 1'b1;                  // single beat
  assign m_wvalid_o = wr_pend_q & ~w_done_q;

  assign m_bready_o = 1'b1;

  assign req.rdata = req.addr[2] ? m_rdata_i[63:32] : m_rdata_i[31:0];
  assign req.done  = rd_done | wr_done;

endmodule

// ==== logic/clint_timer.sv ====
`timescale 1ns/1ns

module clint_timer import bus_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  bus_req_if.target req
);

  logic [63:0] mtime_q;
  logic        done_q;
  word_t       rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q <= '0;
      done_q  <= 1'b0;
    end else begin
      mtime_q <= mtime_q + 64'd1;
      done_q  <= req.req;       // answer one cycle after req
    end
  end

  // addr bit 2 picks the high word
  always_ff @(posedge clk) begin
    if (req.req) begin
      rdata_q <= req.addr[2] ? mtime_q[63:32] : mtime_q[31:0];
    end
  end

  assign req.rdata = rdata_q;
  assign req.done  = done_q;

endmodule

// ==== logic/bus_top.sv ====
`timescale 1ns/1ns

module bus_top import bus_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  input  logic       ifu_arvalid_i,
  input  addr_t      ifu_araddr_i,
  output word_t      ifu_rdata_o,
  output logic       ifu_rvalid_o,

  input  logic       lsu_arvalid_i,
  input  addr_t      lsu_araddr_i,
  input  strb_t      lsu_rstrb_i,
  output word_t      lsu_rdata_o,
  output logic       lsu_rdone_o,

  input  logic       lsu_awvalid_i,
  input  addr_t      lsu_awaddr_i,
  input  word_t      lsu_wdata_i,
  input  strb_t      lsu_wstrb_i,
  output logic       lsu_wdone_o,

  output addr_t      m_araddr_o,
  output axi_size_t  m_arsize_o,
  output axi_len_t   m_arlen_o,
  output axi_burst_t m_arburst_o,
  output axi_id_t    m_arid_o,
  output logic       m_arvalid_o,
  input  logic       m_arready_i,

  input  axi_data_t  m_rdata_i,
  input  logic       m_rvalid_i,
  input  logic       m_rlast_i,
  input  axi_resp_t  m_rresp_i,
  output logic       m_rready_o,

  output addr_t      m_awaddr_o,
  output axi_size_t  m_awsize_o,
  output axi_len_t   m_awlen_o,
  output axi_burst_t m_awburst_o,
  output axi_id_t    m_awid_o,
  output logic       m_awvalid_o,
  input  logic       m_awready_i,

  output axi_data_t  m_wdata_o,
  output strb_t      m_wstrb_o,
  output logic       m_wlast_o,
  output logic       m_wvalid_o,
  input  logic       m_wready_i,

  input  logic       m_bvalid_i,
  input  axi_resp_t  m_bresp_i,
  output logic       m_bready_o
);

  bus_req_if axi_req ();
  bus_req_if tmr_req ();  // rtc reads only

  bus_arbiter u_arbiter (
    .clk           (clk),
    .rst           (rst),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_rdata_o   (ifu_rdata_o),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_rstrb_i   (lsu_rstrb_i),
    .lsu_rdata_o   (lsu_rdata_o),
    .lsu_rdone_o   (lsu_rdone_o),
    .lsu_awvalid_i (lsu_awvalid_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .lsu_wdone_o   (lsu_wdone_o),
    .axi_req       (axi_req.master),
    .tmr_req       (tmr_req.master)
  );

  axi_master_bridge u_bridge (
    .clk         (clk),
    .rst         (rst),
    .req         (axi_req.target),
    .m_araddr_o  (m_araddr_o),
    .m_arsize_o  (m_arsize_o),
    .m_arlen_o   (m_arlen_o),
    .m_arburst_o (m_arburst_o),
    .m_arid_o    (m_arid_o),
    .m_arvalid_o (m_arvalid_o),
    .m_arready_i (m_arready_i),
    .m_rdata_i   (m_rdata_i),
    .m_rvalid_i  (m_rvalid_i),
    .m_rlast_i   (m_rlast_i),
    .m_rresp_i   (m_rresp_i),
    .m_rready_o  (m_rready_o),
    .m_awaddr_o  (m_awaddr_o),
    .m_awsize_o  (m_awsize_o),
    .m_awlen_o   (m_awlen_o),
    .m_awburst_o (m_awburst_o),
    .m_awid_o    (m_awid_o),
    .m_awvalid_o (m_awvalid_o),
    .m_awready_i (m_awready_i),
    .m_wdata_o   (m_wdata_o),
    .m_wstrb_o   (m_wstrb_o),
    .m_wlast_o   (m_wlast_o),
    .m_wvalid_o  (m_wvalid_o),
    .m_wready_i  (m_wready_i),
    .m_bvalid_i  (m_bvalid_i),
    .m_bresp_i   (m_bresp_i),
    .m_bready_o  (m_bready_o)
  );

  clint_timer u_timer (
    .clk (clk),
    .rst (rst),
    .req (tmr_req.target)
  );

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;  // 40 ns period
  end

  initial begin
    rst_o = 1'b1;
    repeat (10) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// ==== sim/axi_mem_model.sv ====
`timescale 1ns/1ns

// single-beat axi4 slave, 256 beats of 64 bits
module axi_mem_model import bus_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  addr_t     araddr_i,
  input  logic      arvalid_i,
  output logic      arready_o,
  output axi_data_t rdata_o,
  output logic      rvalid_o,
  output logic      rlast_o,
  input  addr_t     awaddr_i,
  input  logic      awvalid_i,
  output logic      awready_o,
  input  axi_data_t wdata_i,
  input  strb_t     wstrb_i,
  input  logic      wvalid_i,
  output logic      wready_o,
  output logic      bvalid_o
);

  axi_data_t   mem [0:255];
  int unsigned seed;
  int          ar_wait;
  int          aw_wait;
  int          w_wait;
  logic        aw_got;
  logic        w_got;
  addr_t       aw_addr;
  axi_data_t   w_data;
  strb_t       w_strb;

  function automatic int unsigned lcg_next(int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic word_t fill_word(addr_t a);
    return a ^ 32'ha5a5_0000;
  endfunction

  // counts down a random stall of 0 to 3 cycles, raise when it runs out
  task automatic pace(inout int cnt, output logic raise);
    if (cnt < 0) begin
      seed = lcg_next(seed);
      cnt  = (seed >> 16) % 4;
    end
    raise = (cnt == 0);
    cnt   = raise ? -1 : cnt - 1;
  endtask

  assign rlast_o = 1'b1;

  initial begin
    seed = 17;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {fill_word(addr_t'(i * 8 + 4)), fill_word(addr_t'(i * 8))};
    end
    arready_o <= 1'b0;
    awready_o <= 1'b0;
    wready_o  <= 1'b0;
    rvalid_o  <= 1'b0;
    bvalid_o  <= 1'b0;
    rdata_o   <= '0;
  end

  always @(posedge clk_i) begin
    logic go;
    if (rst_i) begin
      arready_o <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      rvalid_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      ar_wait = -1;
      aw_wait = -1;
      w_wait  = -1;
      aw_got  = 1'b0;
      w_got   = 1'b0;
    end else begin
      rvalid_o <= 1'b0;
      bvalid_o <= 1'b0;
      if (arvalid_i && arready_o) begin
        arready_o <= 1'b0;
        rdata_o   <= mem[araddr_i[10:3]];
        rvalid_o  <= 1'b1;
      end else if (arvalid_i) begin
        pace(ar_wait, go);
        arready_o <= go;
      end
      if (aw_got && w_got) begin  // both halves of the write are in
        for (int b = 0; b < 8; b++) begin
          if (w_strb[b]) mem[aw_addr[10:3]][b*8 +: 8] = w_data[b*8 +: 8];
        end
        bvalid_o <= 1'b1;
        aw_got = 1'b0;
        w_got  = 1'b0;
      end
      if (awvalid_i && awready_o) begin
        awready_o <= 1'b0;
        aw_addr = awaddr_i;
        aw_got  = 1'b1;
      end else if (awvalid_i) begin
        pace(aw_wait, go);
        awready_o <= go;
      end
      if (wvalid_i && wready_o) begin
        wready_o <= 1'b0;
        w_data = wdata_i;
        w_strb = wstrb_i;
        w_got  = 1'b1;
      end else if (wvalid_i) begin
        pace(w_wait, go);
        wready_o <= go;
      end
    end
  end

endmodule

// ==== sim/bus_tb.sv ====
`timescale 1ns/1ns

module bus_tb import bus_pkg::*; ();

  localparam int n_ops       = 22;
  localparam int cycle_limit = 10 + n_ops * 200;

  logic  clk;
  logic  rst;
  logic  ifu_arvalid_i;
  addr_t ifu_araddr_i;
  word_t ifu_rdata_o;
  logic  ifu_rvalid_o;
  logic  lsu_arvalid_i;
  addr_t lsu_araddr_i;
  strb_t lsu_rstrb_i;
  word_t lsu_rdata_o;
  logic  lsu_rdone_o;
  logic  lsu_awvalid_i;
  addr_t lsu_awaddr_i;
  word_t lsu_wdata_i;
  strb_t lsu_wstrb_i;
  logic  lsu_wdone_o;

  addr_t      m_araddr_o;
  addr_t      m_awaddr_o;
  axi_size_t  m_arsize_o;
  axi_size_t  m_awsize_o;
  axi_len_t   m_arlen_o;
  axi_len_t   m_awlen_o;
  axi_burst_t m_arburst_o;
  axi_burst_t m_awburst_o;
  axi_id_t    m_arid_o;
  axi_id_t    m_awid_o;
  axi_resp_t  m_rresp_i;
  axi_resp_t  m_bresp_i;
  axi_data_t  m_rdata_i;
  axi_data_t  m_wdata_o;
  strb_t      m_wstrb_o;
  logic       m_arvalid_o, m_arready_i, m_rvalid_i, m_rlast_i, m_rready_o;
  logic       m_awvalid_o, m_awready_i, m_wlast_o, m_wvalid_o, m_wready_i;
  logic       m_bvalid_i, m_bready_o;

  logic [31:0] pat [0:n_ops*5-1];  // op, addr, wdata, strb, expected
  int          n_mismatch = 0;
  int          n_fail = 0;
  int          cycles = 0;
  int          since_rst = 0;
  int          ar_count = 0;
  axi_size_t   exp_size;
  word_t       last_lo;
  logic        have_lo = 1'b0;

  tb_clock_gen u_clk (
    .clk_o (clk),
    .rst_o (rst)
  );

  bus_top dut (.*);

  axi_mem_model u_mem (
    .clk_i     (clk),
    .rst_i     (rst),
    .araddr_i  (m_araddr_o),
    .arvalid_i (m_arvalid_o),
    .arready_o (m_arready_i),
    .rdata_o   (m_rdata_i),
    .rvalid_o  (m_rvalid_i),
    .rlast_o   (m_rlast_i),
    .awaddr_i  (m_awaddr_o),
    .awvalid_i (m_awvalid_o),
    .awready_o (m_awready_i),
    .wdata_i   (m_wdata_o),
    .wstrb_i   (m_wstrb_o),
    .wvalid_i  (m_wvalid_o),
    .wready_o  (m_wready_i),
    .bvalid_o  (m_bvalid_i)
  );

  assign m_rresp_i = 2'b00;  // okay
  assign m_bresp_i = 2'b00;

  function automatic axi_size_t size_for_strb(strb_t s);
    if (s == 8'h01) return size_byte;
    if (s == 8'h03) return size_half;
    return size_word;
  endfunction

  task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
    n_mismatch++;
    $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (!rst) since_rst <= since_rst + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_fail);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ar, aw and w handshakes, r and b beats
  always @(negedge clk) begin
    if (m_arvalid_o && m_arready_i) begin
      ar_count++;
      assert (m_arsize_o == exp_size) else report_mismatch("m_arsize_o", m_arsize_o, exp_size);
      assert (m_arlen_o == 8'd0) else report_mismatch("m_arlen_o", m_arlen_o, 0);
      assert (m_arburst_o == 2'b01) else report_mismatch("m_arburst_o", m_arburst_o, 2'b01);
      assert (m_arid_o == 4'd0) else report_mismatch("m_arid_o", m_arid_o, 0);
    end
    if (m_awvalid_o && m_awready_i) begin
      assert (m_awsize_o == exp_size) else report_mismatch("m_awsize_o", m_awsize_o, exp_size);
      assert (m_awlen_o == 8'd0) else report_mismatch("m_awlen_o", m_awlen_o, 0);
      assert (m_awburst_o == 2'b01) else report_mismatch("m_awburst_o", m_awburst_o, 2'b01);
      assert (m_awid_o == 4'd0) else report_mismatch("m_awid_o", m_awid_o, 0);
    end
    if (m_wvalid_o && m_wready_i) begin
      assert (m_wlast_o === 1'b1) else report_mismatch("m_wlast_o", m_wlast_o, 1);
    end
    if (m_rvalid_i) begin
      assert (m_rready_o === 1'b1) else report_mismatch("m_rready_o", m_rready_o, 1);
    end
    if (m_bvalid_i) begin
      assert (m_bready_o === 1'b1) else report_mismatch("m_bready_o", m_bready_o, 1);
    end
  end

  // raises the chosen requests together and drops each on its own done strobe
  task automatic run_requests(input logic do_ifu, input logic do_rd, input logic do_wr,
                              input addr_t f_addr, input addr_t l_addr, input word_t wdata,
                              input strb_t strb, output word_t f_data, output word_t l_data,
                              output int latency);
    int f_pulses;
    int l_pulses;
    int edges;
    int quiet;
    f_pulses = 0;
    l_pulses = 0;
    edges    = 0;
    quiet    = 0;
    latency  = 0;
    @(posedge clk);
    ifu_arvalid_i <= do_ifu;
    ifu_araddr_i  <= f_addr;
    lsu_arvalid_i <= do_rd;
    lsu_araddr_i  <= l_addr;
    lsu_rstrb_i   <= strb;
    lsu_awvalid_i <= do_wr;
    lsu_awaddr_i  <= l_addr;
    lsu_wdata_i   <= wdata;
    lsu_wstrb_i   <= strb;
    while (quiet < 4) begin  // quiet cycles catch a repeated strobe
      @(negedge clk);
      edges++;
      if (ifu_rvalid_o) begin
        f_pulses++;
        f_data = ifu_rdata_o;
      end
      if (lsu_rdone_o || lsu_wdone_o) begin
        l_pulses++;
        l_data  = lsu_rdata_o;
        latency = edges;
      end
      if ((f_pulses > 0 || !do_ifu) && (l_pulses > 0 || !(do_rd || do_wr))) quiet++;
      @(posedge clk);
      if (f_pulses > 0) ifu_arvalid_i <= 1'b0;
      if (l_pulses > 0) begin
        lsu_arvalid_i <= 1'b0;
        lsu_awvalid_i <= 1'b0;
      end
    end
    assert (f_pulses == (do_ifu ? 1 : 0)) else begin
      n_fail++;
      $display("ifu_rvalid_o pulsed %0d times for one request at %0t ns", f_pulses, $time);
    end
    assert (l_pulses == ((do_rd || do_wr) ? 1 : 0)) else begin
      n_fail++;
      $display("lsu done strobe pulsed %0d times for one request at %0t ns", l_pulses, $time);
    end
  endtask

  initial begin
    word_t       f_data;
    word_t       l_data;
    int          lat;
    int          ar_before;
    int          i;
    logic [31:0] op;
    addr_t       a;
    word_t       wd;
    strb_t       sb;
    word_t       exp;
    ifu_arvalid_i <= 1'b0;
    ifu_araddr_i  <= '0;
    lsu_arvalid_i <= 1'b0;
    lsu_araddr_i  <= '0;
    lsu_rstrb_i   <= '0;
    lsu_awvalid_i <= 1'b0;
    lsu_awaddr_i  <= '0;
    lsu_wdata_i   <= '0;
    lsu_wstrb_i   <= '0;
    exp_size = size_word;
    $readmemh("sim/bus_patterns.mem", pat);
    assert (!$isunknown(pat[n_ops*5-1])) else begin
      n_fail++;
      $display("pattern file holds fewer than %0d operations", n_ops);
    end
    wait (rst === 1'b0);
    i = 0;
    while (i < n_ops) begin
      op  = pat[i*5];
      a   = pat[i*5+1];
      wd  = pat[i*5+2];
      sb  = pat[i*5+3][7:0];
      exp = pat[i*5+4];
      exp_size  = size_for_strb(sb);
      ar_before = ar_count;
      case (op)
        0: begin
          run_requests(1'b1, 1'b0, 1'b0, a, '0, '0, sb, f_data, l_data, lat);
          assert (f_data == exp) else report_mismatch("ifu_rdata_o", f_data, exp);
        end
        1: begin
          run_requests(1'b0, 1'b1, 1'b0, '0, a, '0, sb, f_data, l_data, lat);
          assert (l_data == exp) else report_mismatch("lsu_rdata_o", l_data, exp);
        end
        2: run_requests(1'b0, 1'b0, 1'b1, '0, a, wd, sb, f_data, l_data, lat);
        3: begin
          run_requests(1'b0, 1'b1, 1'b0, '0, a, '0, sb, f_data, l_data, lat);
          assert (lat == 3) else begin
            n_fail++;
            $display("timer read at %0t ns took %0d cycles instead of 3", $time, lat);
          end
          assert (ar_count == ar_before) else begin
            n_fail++;
            $display("timer read of %0h went out on the axi read channel", a);
          end
          if (a == rtc_addr_hi) begin
            assert (l_data == exp) else report_mismatch("lsu_rdata_o", l_data, exp);
          end else begin
            assert (!have_lo || l_data > last_lo) else begin
              n_fail++;
              $display("mtime low word went from %0d to %0d", last_lo, l_data);
            end
            assert (l_data < since_rst) else begin
              n_fail++;
              $display("mtime %0d is not below %0d cycles since reset", l_data, since_rst);
            end
            last_lo = l_data;
            have_lo = 1'b1;
          end
        end
        4: begin
          i++;  // the racing load sits on the next line
          run_requests(1'b1, 1'b1, 1'b0, a, pat[i*5+1], '0, pat[i*5+3][7:0],
                       f_data, l_data, lat);
          assert (f_data == exp) else report_mismatch("ifu_rdata_o", f_data, exp);
          assert (l_data == pat[i*5+4]) else report_mismatch("lsu_rdata_o", l_data, pat[i*5+4]);
        end
        default: begin
          n_fail++;
          $display("unknown operation %0h in pattern line %0d", op, i);
        end
      endcase
      i++;
    end
    repeat (2) @(posedge clk);
    $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_fail);
    if (n_mismatch == 0 && n_fail == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/bus_patterns.mem ====
// op addr wdata strb expected
// op 0 fetch, 1 load, 2 store, 3 timer read, 4 fetch racing the load on the next line
0 00000000 00000000 0f a5a50000
0 00000004 00000000 0f a5a50004
0 000000f8 00000000 0f a5a500f8
0 000001fc 00000000 0f a5a501fc
0 000007f4 00000000 0f a5a507f4
1 000003a0 00000000 0f a5a503a0
2 00000101 000000ab 01 00000000
1 00000100 00000000 0f a5a5ab00
2 0000010e 00001234 03 00000000
1 0000010c 00000000 0f 1234010c
2 00000118 cafef00d 0f 00000000
1 00000118 00000000 0f cafef00d
2 00000123 00000077 01 00000000
1 00000120 00000000 0f 77a50120
3 02000000 00000000 0f 00000000
3 02000000 00000000 0f 00000000
3 02000004 00000000 0f 00000000
4 00000040 00000000 0f a5a50040
1 0000011c 00000000 0f a5a5011c
4 00000048 00000000 0f a5a50048
1 0000010c 00000000 0f 1234010c
3 02000000 00000000 0f 00000000

// ==== filelist.f ====
logic/bus_pkg.sv
logic/bus_req_if.sv
logic/bus_arbiter.sv
logic/axi_master_bridge.sv
logic/clint_timer.sv
logic/bus_top.sv
sim/tb_clock_gen.sv
sim/axi_mem_model.sv
sim/bus_tb.sv

// ==== Bender.yml ====
package:
  name: rv_mem_bus

sources:
  - logic/bus_pkg.sv
  - logic/bus_req_if.sv
  - logic/bus_arbiter.sv
  - logic/axi_master_bridge.sv
  - logic/clint_timer.sv
  - logic/bus_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/axi_mem_model.sv
      - sim/bus_tb.sv
